// File: rtl/board_pkg.sv
// system bus cycle, response, dma request, page write and port 0x61 types, address map constants
package board_pkg;

   localparam int ADDR_W     = 20;
   localparam int DATA_W     = 8;
   localparam int RAM_ADDR_W = 18;  // 256 KB fitted on the board
   localparam int PAGE_W     = 4;   // LS670 word width

   localparam logic [9:0] PORT_SYSCTL = 10'h061;
   localparam logic [9:0] PORT_STATUS = 10'h062;

   localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;  // floating data lines read high
   localparam int STATUS_IO_CK_BIT = 6;

   // bit 1 marks an i/o cycle, bit 0 a write
   typedef enum logic [1:0] {
      MEM_RD = 2'b00,
      MEM_WR = 2'b01,
      IO_RD  = 2'b10,
      IO_WR  = 2'b11
   } cycle_cmd_e;

   typedef enum logic {
      MASTER_CPU = 1'b0,
      MASTER_DMA = 1'b1
   } bus_master_e;

   // groups of 32 ports picked by address bits 9..5
   typedef enum logic [2:0] {
      SEL_DMA   = 3'd0,
      SEL_PIC   = 3'd1,
      SEL_TIMER = 3'd2,
      SEL_PPI   = 3'd3,
      SEL_PAGE  = 3'd4,
      SEL_NMI   = 3'd5,
      SEL_NONE  = 3'd7
   } io_select_e;

   typedef struct packed {
      logic              strobe;  // one clock per cycle
      cycle_cmd_e        cmd;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } bus_cycle_t;

   typedef struct packed {
      logic              strobe;
      logic [1:0]        chan;
      logic              is_write;  // memory write, else memory read
      logic [15:0]       offset;
      logic [DATA_W-1:0] data;
   } dma_req_t;

   typedef struct packed {
      logic              valid;  // peer saw a cycle in its range
      logic              hit;    // read data below is meaningful
      logic [DATA_W-1:0] rdata;
   } peer_resp_t;

   typedef struct packed {
      logic              valid;
      bus_master_e       master;
      logic [DATA_W-1:0] data;
   } bus_resp_t;

   typedef struct packed {
      logic              strobe;
      logic [1:0]        idx;
      logic [PAGE_W-1:0] page;
   } page_wr_t;

   // port 0x61, msb first
   typedef struct packed {
      logic kbd_clear;
      logic kbd_clk_low;
      logic io_ck_en_n;
      logic ram_parity_ck_n;
      logic motor_off;
      logic spare;
      logic speaker_data;
      logic timer2_gate;
   } sysctl_t;

endpackage

// File: rtl/bus_arbiter.sv
// hold/holda sequencing, cpu or dma cycle onto the system bus, merge of peer read responses
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                  clk,
   input  logic                  reset_n,
   input  board_pkg::bus_cycle_t cpu_cycle_i,
   input  logic                  dma_hold_i,
   input  board_pkg::bus_cycle_t dma_cycle_i,
   input  board_pkg::peer_resp_t ram_resp_i,
   input  board_pkg::peer_resp_t io_resp_i,
   output logic                  holda_o,
   output board_pkg::bus_cycle_t sys_bus_o,
   output board_pkg::bus_resp_t  resp_o
);

   board_pkg::bus_master_e owner;
   board_pkg::bus_cycle_t  sel_cycle;
   logic                   sel_read;
   logic                   holda_q;

   logic                   bus_stb_q;
   board_pkg::bus_cycle_t  bus_cyc_q;     // payload of the cycle on the bus
   board_pkg::bus_master_e bus_master_q;
   logic                   bus_read_q;

   board_pkg::bus_master_e rsp_master_q;  // cycle the peers are answering
   logic                   rsp_read_q;
   logic                   ram_claim;
   logic                   io_claim;

   // hold granted only between cpu strobes, released as soon as dma drops it
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         holda_q <= 1'b0;
      end else if (!holda_q) begin
         holda_q <= dma_hold_i && !cpu_cycle_i.strobe;
      end else begin
         holda_q <= dma_hold_i;
      end
   end

   assign holda_o = holda_q;

   assign owner     = holda_q ? board_pkg::MASTER_DMA : board_pkg::MASTER_CPU;
   assign sel_cycle = holda_q ? dma_cycle_i : cpu_cycle_i;  // the other master is ignored
   assign sel_read  = (sel_cycle.cmd == board_pkg::MEM_RD) ||
                      (sel_cycle.cmd == board_pkg::IO_RD);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         bus_stb_q    <= 1'b0;
         bus_read_q   <= 1'b0;
         bus_master_q <= board_pkg::MASTER_CPU;
         rsp_read_q   <= 1'b0;
         rsp_master_q <= board_pkg::MASTER_CPU;
      end else begin
         bus_stb_q    <= sel_cycle.strobe;
         bus_read_q   <= sel_cycle.strobe && sel_read;
         bus_master_q <= owner;
         rsp_read_q   <= bus_read_q;
         rsp_master_q <= bus_master_q;
      end
   end

   always_ff @(posedge clk) begin
      if (sel_cycle.strobe) begin
         bus_cyc_q <= sel_cycle;
      end
   end

   always_comb begin
      sys_bus_o        = bus_cyc_q;
      sys_bus_o.strobe = bus_stb_q;
   end

   assign ram_claim = ram_resp_i.valid && ram_resp_i.hit;
   assign io_claim  = io_resp_i.valid && io_resp_i.hit;

   // ranges never overlap, so at most one claim
   always_comb begin
      resp_o.valid  = rsp_read_q;
      resp_o.master = rsp_master_q;
      if (ram_claim) begin
         resp_o.data = ram_resp_i.rdata;
      end else if (io_claim) begin
         resp_o.data = io_resp_i.rdata;
      end else begin
         resp_o.data = board_pkg::OPEN_BUS;  // unclaimed read
      end
   end

endmodule

// File: rtl/dma_page_file.sv
// four dma page registers and 20-bit dma address formation
`timescale 1ns/1ps

module dma_page_file (
   input  logic                  clk,
   input  logic                  reset_n,
   input  board_pkg::dma_req_t   dma_req_i,
   input  board_pkg::page_wr_t   page_wr_i,
   output board_pkg::bus_cycle_t dma_cycle_o
);

   // one page per channel, as in the LS670 register file
   logic [board_pkg::PAGE_W-1:0] page_q [4];

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int i = 0; i < 4; i++) begin
            page_q[i] <= '0;
         end
      end else if (page_wr_i.strobe) begin
         page_q[page_wr_i.idx] <= page_wr_i.page;
      end
   end

   // the 8237 only gives 16 address bits, the page supplies 19..16
   always_comb begin
      dma_cycle_o.strobe = dma_req_i.strobe;
      if (dma_req_i.is_write) begin
         dma_cycle_o.cmd = board_pkg::MEM_WR;
      end else begin
         dma_cycle_o.cmd = board_pkg::MEM_RD;
      end
      dma_cycle_o.addr  = {page_q[dma_req_i.chan], dma_req_i.offset};
      dma_cycle_o.wdata = dma_req_i.data;
   end

endmodule

// File: rtl/io_ports.sv
// i/o group decode, port 0x61 and nmi mask registers, channel-check latch, port 0x61/0x62 reads
`timescale 1ns/1ps

module io_ports (
   input  logic                  clk,
   input  logic                  reset_n,
   input  board_pkg::bus_cycle_t sys_bus_i,
   input  logic                  io_ch_ck_n_i,
   output board_pkg::peer_resp_t io_resp_o,
   output board_pkg::page_wr_t   page_wr_o,
   output board_pkg::sysctl_t    sysctl_o,
   output logic                  nmi_o
);

   board_pkg::io_select_e sel;
   board_pkg::sysctl_t    sysctl_q;
   logic                  io_rd;
   logic                  io_wr;
   logic                  sysctl_hit;
   logic                  status_hit;
   logic                  nmi_mask_q;
   logic                  io_ck_q;   // channel-check latch
   logic [board_pkg::DATA_W-1:0] status_byte;

   assign io_rd = sys_bus_i.strobe && (sys_bus_i.cmd == board_pkg::IO_RD);
   assign io_wr = sys_bus_i.strobe && (sys_bus_i.cmd == board_pkg::IO_WR);

   // LS138 style, bits 9 and 8 act as enables
   always_comb begin
      if (sys_bus_i.addr[9:8] != 2'b00) begin
         sel = board_pkg::SEL_NONE;
      end else begin
         case (sys_bus_i.addr[7:5])
            3'd0:    sel = board_pkg::SEL_DMA;
            3'd1:    sel = board_pkg::SEL_PIC;
            3'd2:    sel = board_pkg::SEL_TIMER;
            3'd3:    sel = board_pkg::SEL_PPI;
            3'd4:    sel = board_pkg::SEL_PAGE;
            3'd5:    sel = board_pkg::SEL_NMI;
            default: sel = board_pkg::SEL_NONE;
         endcase
      end
   end

   assign sysctl_hit = (sel == board_pkg::SEL_PPI) &&
                       (sys_bus_i.addr[4:0] == board_pkg::PORT_SYSCTL[4:0]);
   assign status_hit = (sel == board_pkg::SEL_PPI) &&
                       (sys_bus_i.addr[4:0] == board_pkg::PORT_STATUS[4:0]);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         sysctl_q   <= '0;
         nmi_mask_q <= 1'b0;
         io_ck_q    <= 1'b0;
      end else begin
         if (io_wr && sysctl_hit) begin
            sysctl_q <= sys_bus_i.wdata;
         end
         if (io_wr && (sel == board_pkg::SEL_NMI)) begin
            nmi_mask_q <= sys_bus_i.wdata[7];  // any port in the 0xA0 group
         end
         if (sysctl_q.io_ck_en_n) begin
            io_ck_q <= 1'b0;
         end else if (!io_ch_ck_n_i) begin
            io_ck_q <= 1'b1;
         end
      end
   end

   always_comb begin
      status_byte = '0;
      status_byte[board_pkg::STATUS_IO_CK_BIT] = io_ck_q;
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         io_resp_o <= '0;
      end else begin
         io_resp_o.valid <= io_rd || io_wr;
         io_resp_o.hit   <= io_rd && (sysctl_hit || status_hit);
         io_resp_o.rdata <= sysctl_hit ? sysctl_q : status_byte;
      end
   end

   // page write goes straight to the LS670
   assign page_wr_o.strobe = io_wr && (sel == board_pkg::SEL_PAGE);
   assign page_wr_o.idx    = sys_bus_i.addr[1:0];
   assign page_wr_o.page   = sys_bus_i.wdata[board_pkg::PAGE_W-1:0];

   assign sysctl_o = sysctl_q;
   assign nmi_o    = nmi_mask_q && io_ck_q;

endmodule

// File: rtl/system_ram.sv
// 256 KB byte-wide RAM on the system bus, one-cycle registered read
`timescale 1ns/1ps

module system_ram (
   input  logic                  clk,
   input  board_pkg::bus_cycle_t sys_bus_i,
   output board_pkg::peer_resp_t ram_resp_o
);

   localparam int DEPTH = 2 ** board_pkg::RAM_ADDR_W;

   logic [board_pkg::DATA_W-1:0]     mem [DEPTH];
   logic [board_pkg::RAM_ADDR_W-1:0] ram_addr;
   logic                             mem_cyc;
   logic                             ram_sel;
   logic                             ram_wr;
   logic                             ram_rd;

   assign mem_cyc = (sys_bus_i.cmd == board_pkg::MEM_RD) ||
                    (sys_bus_i.cmd == board_pkg::MEM_WR);

   // a19 and a18 both low selects the RAM bank
   assign ram_sel  = sys_bus_i.strobe && mem_cyc &&
                     (sys_bus_i.addr[board_pkg::ADDR_W-1:board_pkg::RAM_ADDR_W] == 2'b00);
   assign ram_wr   = ram_sel && (sys_bus_i.cmd == board_pkg::MEM_WR);
   assign ram_rd   = ram_sel && (sys_bus_i.cmd == board_pkg::MEM_RD);
   assign ram_addr = sys_bus_i.addr[board_pkg::RAM_ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (ram_wr) begin
         mem[ram_addr] <= sys_bus_i.wdata;
      end
      ram_resp_o.rdata <= mem[ram_addr];  // old data on a write, ignored then
   end

   // strobe on the bus is cleared by reset, so valid settles one clock later
   always_ff @(posedge clk) begin
      ram_resp_o.valid <= ram_sel;
      ram_resp_o.hit   <= ram_rd;
   end

endmodule

// File: rtl/system_board.sv
// system board top: arbiter, dma page file, i/o ports and RAM on one system bus
`timescale 1ns/1ps

module system_board (
   input  logic                  clk,
   input  logic                  reset_n,
   input  board_pkg::bus_cycle_t cpu_cycle_i,
   input  logic                  dma_hold_i,
   input  board_pkg::dma_req_t   dma_req_i,
   input  logic                  io_ch_ck_n_i,
   output logic                  holda_o,
   output board_pkg::bus_resp_t  resp_o,
   output board_pkg::sysctl_t    sysctl_o,
   output logic                  nmi_o
);

   board_pkg::bus_cycle_t sys_bus;     // driven by the arbiter only
   board_pkg::bus_cycle_t dma_cycle;   // dma request with page applied
   board_pkg::peer_resp_t ram_resp;
   board_pkg::peer_resp_t io_resp;
   board_pkg::page_wr_t   page_wr;

   bus_arbiter i_bus_arbiter (
      .clk         (clk),
      .reset_n     (reset_n),
      .cpu_cycle_i (cpu_cycle_i),
      .dma_hold_i  (dma_hold_i),
      .dma_cycle_i (dma_cycle),
      .ram_resp_i  (ram_resp),
      .io_resp_i   (io_resp),
      .holda_o     (holda_o),
      .sys_bus_o   (sys_bus),
      .resp_o      (resp_o)
   );

   dma_page_file i_dma_page_file (
      .clk         (clk),
      .reset_n     (reset_n),
      .dma_req_i   (dma_req_i),
      .page_wr_i   (page_wr),
      .dma_cycle_o (dma_cycle)
   );

   io_ports i_io_ports (
      .clk          (clk),
      .reset_n      (reset_n),
      .sys_bus_i    (sys_bus),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .io_resp_o    (io_resp),
      .page_wr_o    (page_wr),
      .sysctl_o     (sysctl_o),
      .nmi_o        (nmi_o)
   );

   system_ram i_system_ram (
      .clk        (clk),
      .sys_bus_i  (sys_bus),
      .ram_resp_o (ram_resp)
   );

endmodule

// File: dv/system_board_asserts.sv
// concurrent checks on the bus arbiter: hold handshake, bus ownership, response spacing
`timescale 1ns/1ps

module system_board_asserts (
   input logic                  clk,
   input logic                  reset_n,
   input board_pkg::bus_cycle_t cpu_cycle_i,
   input logic                  dma_hold_i,
   input board_pkg::bus_cycle_t dma_cycle_i,
   input logic                  holda_o,
   input board_pkg::bus_cycle_t sys_bus_o,
   input board_pkg::bus_resp_t  resp_o
);

   board_pkg::bus_cycle_t owned_cycle;  // cycle of the master that owns the bus
   logic                  read_taken;
   int                    fail_count = 0;

   assign owned_cycle = holda_o ? dma_cycle_i : cpu_cycle_i;
   assign read_taken  = owned_cycle.strobe &&
                        ((owned_cycle.cmd == board_pkg::MEM_RD) ||
                         (owned_cycle.cmd == board_pkg::IO_RD));

   // grant only between cpu strobes
   holda_needs_hold: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(holda_o) |-> $past(dma_hold_i && !cpu_cycle_i.strobe))
      else begin
         $error("holda_o rose without dma_hold_i or during a cpu strobe");
         fail_count++;
      end

   // bus carries exactly what the owner strobed one edge earlier
   bus_from_owner: assert property (@(posedge clk) disable iff (!reset_n)
      sys_bus_o.strobe |-> (sys_bus_o == $past(owned_cycle)))
      else begin
         $error("sys_bus_o carries a cycle the bus owner did not strobe");
         fail_count++;
      end

   resp_spacing: assert property (@(posedge clk) disable iff (!reset_n)
      (resp_o.valid && $past(resp_o.valid)) |-> ($past(read_taken, 2) && $past(read_taken, 3)))
      else begin
         $error("resp_o valid twice in a row without back-to-back reads");
         fail_count++;
      end

endmodule

bind bus_arbiter system_board_asserts i_system_board_asserts (
   .clk         (clk),
   .reset_n     (reset_n),
   .cpu_cycle_i (cpu_cycle_i),
   .dma_hold_i  (dma_hold_i),
   .dma_cycle_i (dma_cycle_i),
   .holda_o     (holda_o),
   .sys_bus_o   (sys_bus_o),
   .resp_o      (resp_o)
);

// File: dv/tb_system_board.sv
// testbench for system_board: clock, reset, bus stimulus tasks, reference model, response checking
`timescale 1ns/1ps

module tb_system_board;

   localparam int TIMEOUT = 50;  // cycles allowed for any wait

   logic                  clk;
   logic                  reset_n;
   board_pkg::bus_cycle_t cpu_cycle;
   logic                  dma_hold;
   board_pkg::dma_req_t   dma_req;
   logic                  io_ch_ck_n;
   logic                  holda;
   board_pkg::bus_resp_t  resp;
   board_pkg::sysctl_t    sysctl;
   logic                  nmi;

   logic [7:0] model_ram [2**board_pkg::RAM_ADDR_W];
   logic [3:0] model_page [4];
   logic [7:0] model_sysctl;
   logic       model_mask;
   logic       model_latch;
   logic       hold_owned;   // dma side holds the bus

   logic [7:0]             exp_data_q [$];
   board_pkg::bus_master_e exp_master_q [$];
   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int errors_at_start;

   system_board i_system_board (
      .clk          (clk),
      .reset_n      (reset_n),
      .cpu_cycle_i  (cpu_cycle),
      .dma_hold_i   (dma_hold),
      .dma_req_i    (dma_req),
      .io_ch_ck_n_i (io_ch_ck_n),
      .holda_o      (holda),
      .resp_o       (resp),
      .sysctl_o     (sysctl),
      .nmi_o        (nmi)
   );

   always #10 clk = ~clk;

   task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      end
   endtask

   // expected read data from the board rules
   function automatic logic [7:0] ref_read(input logic is_io, input logic [19:0] addr);
      if (!is_io) begin
         return (addr[19:18] == 2'b00) ? model_ram[addr[17:0]] : 8'hFF;
      end
      if (addr[9:0] == board_pkg::PORT_SYSCTL) begin
         return model_sysctl;
      end
      if (addr[9:0] == board_pkg::PORT_STATUS) begin
         return {1'b0, model_latch, 6'b0};  // latch on bit 6
      end
      return 8'hFF;
   endfunction

   // responses arrive in issue order
   always @(negedge clk) begin
      if (reset_n && resp.valid) begin
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("resp_o went valid with no read outstanding at %0t", $time);
         end else begin
            check("resp_o.data", 32'(resp.data), 32'(exp_data_q.pop_front()));
            check("resp_o.master", 32'(resp.master), 32'(exp_master_q.pop_front()));
         end
      end
   end

   task automatic cpu_write(input logic is_io, input logic [19:0] addr, input logic [7:0] data);
      @(negedge clk);
      cpu_cycle.strobe = 1'b1;
      cpu_cycle.cmd    = is_io ? board_pkg::IO_WR : board_pkg::MEM_WR;
      cpu_cycle.addr   = addr;
      cpu_cycle.wdata  = data;
      if (!is_io && addr[19:18] == 2'b00) begin
         model_ram[addr[17:0]] = data;
      end
      if (is_io && addr[9:0] == board_pkg::PORT_SYSCTL) begin
         model_sysctl = data;
      end
      if (is_io && addr[9:5] == 5'h05) begin
         model_mask = data[7];    // whole 0xA0 group
      end
      if (is_io && addr[9:5] == 5'h04) begin
         model_page[addr[1:0]] = data[3:0];
      end
   endtask

   task automatic cpu_read(input logic is_io, input logic [19:0] addr);
      @(negedge clk);
      cpu_cycle.strobe = 1'b1;
      cpu_cycle.cmd    = is_io ? board_pkg::IO_RD : board_pkg::MEM_RD;
      cpu_cycle.addr   = addr;
      exp_data_q.push_back(ref_read(is_io, addr));
      exp_master_q.push_back(board_pkg::MASTER_CPU);
   endtask

   task automatic dma_write(input logic [1:0] chan, input logic [15:0] offset, input logic [7:0] data);
      @(negedge clk);
      dma_req.strobe   = 1'b1;
      dma_req.chan     = chan;
      dma_req.is_write = 1'b1;
      dma_req.offset   = offset;
      dma_req.data     = data;
      if (hold_owned && model_page[chan][3:2] == 2'b00) begin
         model_ram[{model_page[chan][1:0], offset}] = data;
      end
   endtask

   task automatic dma_read(input logic [1:0] chan, input logic [15:0] offset);
      @(negedge clk);
      dma_req.strobe   = 1'b1;
      dma_req.chan     = chan;
      dma_req.is_write = 1'b0;
      dma_req.offset   = offset;
      exp_data_q.push_back(ref_read(1'b0, {model_page[chan], offset}));
      exp_master_q.push_back(board_pkg::MASTER_DMA);
   endtask

   task automatic bus_idle();
      @(negedge clk);
      cpu_cycle.strobe = 1'b0;
      dma_req.strobe   = 1'b0;
   endtask

   task automatic wait_holda(input logic level);
      int n;
      n = 0;
      while (holda !== level && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (holda !== level) begin
         errors++;
         $display("timed out waiting for holda_o to become %0b", level);
      end
   endtask

   task automatic request_hold();
      bus_idle();
      dma_hold = 1'b1;
      wait_holda(1'b1);
      hold_owned = 1'b1;
   endtask

   task automatic release_hold();
      bus_idle();
      dma_hold   = 1'b0;
      hold_owned = 1'b0;
      wait_holda(1'b0);
   endtask

   task automatic wait_nmi(input logic level);
      int n;
      n = 0;
      while (nmi !== level && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (nmi !== level) begin
         errors++;
         $display("timed out waiting for nmi_o to become %0b", level);
      end
   endtask

   task automatic pulse_channel_check();
      bus_idle();
      io_ch_ck_n = 1'b0;
      @(negedge clk);
      io_ch_ck_n = 1'b1;
      if (!model_sysctl[5]) begin
         model_latch = 1'b1;  // io_ck_en_n low lets it set
      end
   endtask

   task automatic finish_test(input string name);
      int n;
      bus_idle();
      n = 0;
      while (exp_data_q.size() != 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_data_q.size() != 0) begin
         errors++;
         $display("%0d read responses never arrived in test %s", exp_data_q.size(), name);
         exp_data_q.delete();
         exp_master_q.delete();
      end
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s done: ok", name);
      end else begin
         tests_failed++;
         $display("test %s done: %0d errors", name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial begin : main
      logic [19:0] addr_list [8];
      logic [15:0] offs [4];
      logic [7:0]  d;
      logic [3:0]  pg;
      int          j;
      void'($urandom(96));
      clk = 1'b0;
      reset_n = 1'b0;
      cpu_cycle = '0;
      dma_hold = 1'b0;
      dma_req = '0;
      io_ch_ck_n = 1'b1;
      model_sysctl = 8'h00;
      model_mask = 1'b0;
      model_latch = 1'b0;
      hold_owned = 1'b0;
      for (int i = 0; i < 4; i++) begin
         model_page[i] = 4'h0;
      end
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      errors_at_start = 0;
      repeat (4) @(posedge clk);
      check("holda_o", 32'(holda), 32'h0);
      check("resp_o.valid", 32'(resp.valid), 32'h0);
      check("sysctl_o", 32'(sysctl), 32'h0);
      check("nmi_o", 32'(nmi), 32'h0);
      @(negedge clk);
      reset_n = 1'b1;
      finish_test("reset");

      // back-to-back writes and reads in RAM
      for (int i = 0; i < 8; i++) begin
         addr_list[i] = {2'b00, 18'($urandom())};
         cpu_write(1'b0, addr_list[i], 8'($urandom()));
         cpu_read(1'b0, addr_list[i]);
      end
      for (int i = 0; i < 24; i++) begin
         j = $urandom_range(0, 7);
         if ($urandom() % 3 == 0) begin
            cpu_write(1'b0, addr_list[j], 8'($urandom()));
         end else begin
            cpu_read(1'b0, addr_list[j]);
         end
      end
      finish_test("cpu ram access");

      d = 8'($urandom());
      cpu_write(1'b0, addr_list[0], d);
      for (int a = 1; a < 4; a++) begin
         cpu_read(1'b0, {2'(a), addr_list[0][17:0]});
         cpu_write(1'b0, {2'(a), addr_list[0][17:0]}, ~d);  // alias above RAM
         cpu_read(1'b0, addr_list[0]);
      end
      finish_test("unmapped memory");

      d = 8'($urandom());
      cpu_write(1'b1, 20'h00061, d);
      cpu_read(1'b1, 20'h00061);
      bus_idle();
      check("sysctl_o", 32'(sysctl), 32'(d));
      cpu_read(1'b1, 20'h003F8);
      cpu_read(1'b1, 20'h00062);
      finish_test("system control port");

      for (int ch = 0; ch < 4; ch++) begin
         pg = (ch < 2) ? {2'b00, 2'($urandom())} : 4'($urandom());
         cpu_write(1'b1, 20'h00080 + 20'(ch), {4'($urandom()), pg});
      end
      request_hold();
      for (int ch = 0; ch < 4; ch++) begin
         offs[ch] = 16'($urandom());
         dma_write(2'(ch), offs[ch], 8'($urandom()));
         dma_read(2'(ch), offs[ch]);
      end
      release_hold();
      for (int ch = 0; ch < 4; ch++) begin
         cpu_read(1'b0, {model_page[ch], offs[ch]});
      end
      bus_idle();
      // no hold, must be dropped
      dma_write(2'd0, offs[0], ~model_ram[{model_page[0][1:0], offs[0]}]);
      bus_idle();
      cpu_read(1'b0, {model_page[0], offs[0]});
      finish_test("dma through page registers");

      cpu_write(1'b1, 20'h00061, 8'h00);
      cpu_write(1'b1, 20'h000A0, 8'h80);
      pulse_channel_check();
      wait_nmi(1'b1);
      cpu_read(1'b1, 20'h00062);
      cpu_write(1'b1, 20'h00061, 8'h20);  // io_ck_en_n high clears the latch
      bus_idle();
      model_latch = 1'b0;
      wait_nmi(1'b0);
      cpu_read(1'b1, 20'h00062);
      cpu_write(1'b1, 20'h00061, 8'h00);
      cpu_write(1'b1, 20'h000A0, 8'h00);
      pulse_channel_check();
      repeat (5) begin
         @(negedge clk);
         check("nmi_o", 32'(nmi), 32'(model_mask && model_latch));
      end
      cpu_read(1'b1, 20'h00062);
      finish_test("channel check and nmi");

      errors = errors + i_system_board.i_bus_arbiter.i_system_board_asserts.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
rtl/board_pkg.sv
rtl/bus_arbiter.sv
rtl/dma_page_file.sv
rtl/io_ports.sv
rtl/system_ram.sv
rtl/system_board.sv
dv/system_board_asserts.sv
dv/tb_system_board.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_system_board \
   && ./obj_dir/Vtb_system_board | tee /dev/stderr | grep -q "Verification passed" \
   && echo "run.sh: simulation ok" \
   || { echo "run.sh: simulation not ok"; exit 1; }
